// File: hdl/riscvPkg.sv
// Shared widths, encodings and stage payloads of the RV32I pipeline core
// Only the integer subset listed in the opcode and funct3 constants is decoded
package riscvPkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam logic [XLEN-1:0] INITIAL_PC  = 32'h0040_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt
    } aluOp_t;

    typedef enum logic [1:0] {
        none,
        fromMem,
        fromWb
    } fwdSel_t;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1Data;
        logic [XLEN-1:0]       rs2Data;
        logic [XLEN-1:0]       imm;
        logic                  useImm;
        aluOp_t                aluOp;
        logic [2:0]            funct3;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  isBranch;
    } idExBus_t;

    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  branchTaken;
        logic [XLEN-1:0]       branchTarget;
    } exMemBus_t;

    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        logic                  memToReg;
    } memWbBus_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] writeData;
        logic            read;
        logic            write;
    } dataMemReq_t;

endpackage

// File: hdl/fetchUnit.sv
// Program counter and IF/ID register
// A redirect wins over a stall; a flushed IF/ID holds a no-op
module fetchUnit import riscvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirectPc,
    input  logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] ifInstr,
    output logic [XLEN-1:0] ifPc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= INITIAL_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + INSTR_BYTES;
        end
    end

    // Squashed slot decodes as addi x0, x0, 0
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ifInstr <= NOP_INSTR;
        end else if (!stall) begin
            ifInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifPc <= pc;
        end
    end

endmodule

// File: hdl/instrDecoder.sv
// Decode stage and ID/EX register
// Unknown opcodes decode as bubbles; unused source indices are forced to x0
module instrDecoder import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       ifInstr,
    input  logic [XLEN-1:0]       ifPc,
    input  logic                  stall,
    input  logic                  flush,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic                  rs1Used,
    output logic                  rs2Used,
    input  logic [XLEN-1:0]       rdData1,
    input  logic [XLEN-1:0]       rdData2,
    output idExBus_t              idEx
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    idExBus_t   decoded;

    assign opcode = ifInstr[6:0];
    assign funct3 = ifInstr[14:12];
    assign funct7 = ifInstr[31:25];

    // Source registers by format
    assign rs1Used = opcode inside {OP_RTYPE, OP_ITYPE, OP_LOAD, OP_STORE, OP_BRANCH};
    assign rs2Used = opcode inside {OP_RTYPE, OP_STORE, OP_BRANCH};
    assign rs1     = rs1Used ? ifInstr[19:15] : '0;
    assign rs2     = rs2Used ? ifInstr[24:20] : '0;

    //////////////////////////////////////////////////
    // Control fields
    //////////////////////////////////////////////////
    always_comb begin
        decoded          = '0;
        decoded.pc       = ifPc;
        decoded.rs1      = rs1;
        decoded.rs2      = rs2;
        decoded.rs1Data  = rdData1;
        decoded.rs2Data  = rdData2;
        decoded.funct3   = funct3;
        decoded.regWrite = opcode inside {OP_RTYPE, OP_ITYPE, OP_LOAD};
        decoded.memRead  = (opcode == OP_LOAD);
        decoded.memWrite = (opcode == OP_STORE);
        decoded.isBranch = (opcode == OP_BRANCH);
        decoded.useImm   = opcode inside {OP_ITYPE, OP_LOAD, OP_STORE};
        decoded.rd       = decoded.regWrite ? ifInstr[11:7] : '0;

        // Immediate by format
        case (opcode)
            OP_STORE:
                decoded.imm = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
            OP_BRANCH:
                decoded.imm = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7],
                               ifInstr[30:25], ifInstr[11:8], 1'b0};
            default:
                decoded.imm = {{20{ifInstr[31]}}, ifInstr[31:20]};
        endcase

        // Loads, stores and branches use add
        decoded.aluOp = aluAdd;
        if (opcode == OP_RTYPE || opcode == OP_ITYPE) begin
            case (funct3)
                F3_ADD: begin
                    if (opcode == OP_RTYPE && funct7 == F7_ALT) begin
                        decoded.aluOp = aluSub;
                    end
                end
                F3_SLL: decoded.aluOp = aluSll;
                F3_SLT: decoded.aluOp = aluSlt;
                F3_XOR: decoded.aluOp = aluXor;
                F3_SR:  decoded.aluOp = (funct7 == F7_ALT) ? aluSra : aluSrl;
                F3_OR:  decoded.aluOp = aluOr;
                F3_AND: decoded.aluOp = aluAnd;
                default: decoded.aluOp = aluAdd;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        idEx <= decoded;
        // Bubble on stall or flush
        if (rst || stall || flush) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.isBranch <= 1'b0;
        end
    end

endmodule

// File: hdl/regFile.sv
// 32 x XLEN register file, two read ports, one write port
// Reads see a same-cycle write; x0 always reads zero
module regFile import riscvPkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rdData1,
    output logic [XLEN-1:0]       rdData2,
    input  memWbBus_t             wb,
    input  logic [XLEN-1:0]       wbData
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            writeEn;

    assign writeEn = wb.regWrite && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[wb.rd] <= wbData;
        end
    end

    // Write-first bypass
    always_comb begin
        rdData1 = (rs1 == '0) ? '0 : (writeEn && wb.rd == rs1) ? wbData : regs[rs1];
        rdData2 = (rs2 == '0) ? '0 : (writeEn && wb.rd == rs2) ? wbData : regs[rs2];
    end

endmodule

// File: hdl/hazardControl.sv
// Stall, flush and forwarding-select decisions for the whole pipeline
// Forwarding selects refer to the instruction currently in EX
module hazardControl import riscvPkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  rs1Used,
    input  logic                  rs2Used,
    input  idExBus_t              idEx,
    input  exMemBus_t             exMem,
    input  memWbBus_t             memWb,
    input  logic                  redirect,
    output logic                  stall,
    output logic                  flush,
    output logic                  iMemRead,
    output fwdSel_t               fwdA,
    output fwdSel_t               fwdB
);

    logic loadUse;

    // Youngest writer wins; a load is only taken from WB
    function automatic fwdSel_t pickSource(logic [REG_ADDR_W-1:0] src,
                                           exMemBus_t mem, memWbBus_t wb);
        fwdSel_t sel;
        sel = none;
        if (src != '0) begin
            if (mem.regWrite && !mem.memRead && mem.rd == src) begin
                sel = fromMem;
            end else if (wb.regWrite && wb.rd == src) begin
                sel = fromWb;
            end
        end
        return sel;
    endfunction

    // Load in EX feeding the instruction in ID
    assign loadUse = idEx.memRead && (idEx.rd != '0) &&
                     ((rs1Used && rs1 == idEx.rd) || (rs2Used && rs2 == idEx.rd));

    // Flush overrides stall
    assign flush    = redirect;
    assign stall    = loadUse && !redirect;
    assign iMemRead = !stall;

    assign fwdA = pickSource(idEx.rs1, exMem, memWb);
    assign fwdB = pickSource(idEx.rs2, exMem, memWb);

endmodule

// File: hdl/executeUnit.sv
// Execute stage: forwarding muxes, ALU, branch decision and EX/MEM register
// Branch compares are direct signed or equality compares on the forwarded operands
module executeUnit import riscvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  idExBus_t        idEx,
    input  fwdSel_t         fwdA,
    input  fwdSel_t         fwdB,
    input  logic [XLEN-1:0] memResult,
    input  logic [XLEN-1:0] wbData,
    input  logic            flush,
    output exMemBus_t       exMem
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            condMet;

    function automatic logic [XLEN-1:0] fwdMux(fwdSel_t sel, logic [XLEN-1:0] regVal,
                                               logic [XLEN-1:0] memVal,
                                               logic [XLEN-1:0] wbVal);
        case (sel)
            fromMem: return memVal;
            fromWb:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdA, idEx.rs1Data, memResult, wbData);
    assign opB  = fwdMux(fwdB, idEx.rs2Data, memResult, wbData);
    assign aluB = idEx.useImm ? idEx.imm : opB;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (idEx.aluOp)
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluXor:  aluResult = opA ^ aluB;
            aluSll:  aluResult = opA << aluB[4:0];
            aluSrl:  aluResult = opA >> aluB[4:0];
            aluSra:  aluResult = $unsigned($signed(opA) >>> aluB[4:0]);
            aluSlt:  aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;
        endcase
    end

    // Branch condition
    always_comb begin
        case (idEx.funct3)
            F3_BEQ:  condMet = (opA == opB);
            F3_BNE:  condMet = (opA != opB);
            F3_BLT:  condMet = ($signed(opA) < $signed(opB));
            F3_BGE:  condMet = ($signed(opA) >= $signed(opB));
            default: condMet = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        exMem.aluResult    <= aluResult;
        exMem.storeData    <= opB;
        exMem.rd           <= idEx.rd;
        exMem.branchTarget <= idEx.pc + idEx.imm;
        if (rst || flush) begin
            exMem.regWrite    <= 1'b0;
            exMem.memRead     <= 1'b0;
            exMem.memWrite    <= 1'b0;
            exMem.branchTaken <= 1'b0;
        end else begin
            exMem.regWrite    <= idEx.regWrite;
            exMem.memRead     <= idEx.memRead;
            exMem.memWrite    <= idEx.memWrite;
            exMem.branchTaken <= idEx.isBranch && condMet;
        end
    end

endmodule

// File: hdl/memWriteback.sv
// Memory stage request, branch redirect, MEM/WB register and writeback mux
// Load data is expected on dReadData in the cycle after the read strobe
module memWriteback import riscvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  exMemBus_t       exMem,
    input  logic [XLEN-1:0] dReadData,
    output dataMemReq_t     dataReq,
    output logic            redirect,
    output logic [XLEN-1:0] redirectPc,
    output memWbBus_t       memWb,
    output logic [XLEN-1:0] wbData
);

    // Word access only
    always_comb begin
        dataReq.addr      = exMem.aluResult;
        dataReq.writeData = exMem.storeData;
        dataReq.read      = exMem.memRead;
        dataReq.write     = exMem.memWrite;
    end

    assign redirect   = exMem.branchTaken;
    assign redirectPc = exMem.branchTarget;

    always_ff @(posedge clk) begin
        memWb.aluResult <= exMem.aluResult;
        memWb.rd        <= exMem.rd;
        if (rst) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memRead;
        end
    end

    assign wbData = memWb.memToReg ? dReadData : memWb.aluResult;

endmodule

// File: hdl/riscvCore.sv
// Five-stage RV32I subset core with forwarding, load-use stall and branch flush
// Instruction memory must answer combinationally, data memory one cycle after read
// Memories are assumed always ready
module riscvCore import riscvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] dReadData,
    output logic [XLEN-1:0] pc,
    output logic            iMemRead,
    output dataMemReq_t     dataReq
);

    logic [XLEN-1:0]       ifInstr;
    logic [XLEN-1:0]       ifPc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs1Used;
    logic                  rs2Used;
    logic [XLEN-1:0]       rdData1;
    logic [XLEN-1:0]       rdData2;
    idExBus_t              idEx;
    exMemBus_t             exMem;
    memWbBus_t             memWb;
    logic [XLEN-1:0]       wbData;
    logic                  stall;
    logic                  flush;
    logic                  redirect;
    logic [XLEN-1:0]       redirectPc;
    fwdSel_t               fwdA;
    fwdSel_t               fwdB;

    fetchUnit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instr     (instr),
        .pc        (pc),
        .ifInstr   (ifInstr),
        .ifPc      (ifPc)
    );

    instrDecoder u_decode (
        .clk    (clk),
        .rst    (rst),
        .ifInstr(ifInstr),
        .ifPc   (ifPc),
        .stall  (stall),
        .flush  (flush),
        .rs1    (rs1),
        .rs2    (rs2),
        .rs1Used(rs1Used),
        .rs2Used(rs2Used),
        .rdData1(rdData1),
        .rdData2(rdData2),
        .idEx   (idEx)
    );

    regFile u_regs (
        .clk    (clk),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdData1(rdData1),
        .rdData2(rdData2),
        .wb     (memWb),
        .wbData (wbData)
    );

    hazardControl u_hazard (
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Used (rs1Used),
        .rs2Used (rs2Used),
        .idEx    (idEx),
        .exMem   (exMem),
        .memWb   (memWb),
        .redirect(redirect),
        .stall   (stall),
        .flush   (flush),
        .iMemRead(iMemRead),
        .fwdA    (fwdA),
        .fwdB    (fwdB)
    );

    executeUnit u_execute (
        .clk      (clk),
        .rst      (rst),
        .idEx     (idEx),
        .fwdA     (fwdA),
        .fwdB     (fwdB),
        .memResult(exMem.aluResult),
        .wbData   (wbData),
        .flush    (flush),
        .exMem    (exMem)
    );

    memWriteback u_memWb (
        .clk       (clk),
        .rst       (rst),
        .exMem     (exMem),
        .dReadData (dReadData),
        .dataReq   (dataReq),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .memWb     (memWb),
        .wbData    (wbData)
    );

endmodule

// File: test/riscvCore_props.sv
// Bound checks on riscvCore: reset state, exclusive data strobes, one-cycle stalls
// Assumes the synchronous active-high reset of the core
module riscvCoreProps import riscvPkg::*; (
    input logic            clk,
    input logic            rst,
    input logic [XLEN-1:0] pc,
    input logic            iMemRead,
    input dataMemReq_t     dataReq
);

    // State after a reset edge
    resetState: assert property (@(posedge clk)
        rst |=> (pc == INITIAL_PC && !dataReq.read && !dataReq.write))
        else $error("pc or data strobes not in reset state after reset");

    strobesExclusive: assert property (@(posedge clk) disable iff (rst)
        !(dataReq.read && dataReq.write))
        else $error("data read and write strobes high together");

    // A load-use stall holds pc for one cycle only
    stallHoldsPc: assert property (@(posedge clk) disable iff (rst)
        !iMemRead |=> pc == $past(pc))
        else $error("pc moved during a stall");

    stallOneCycle: assert property (@(posedge clk) disable iff (rst)
        !iMemRead |=> iMemRead)
        else $error("stall lasted more than one cycle");

endmodule

bind riscvCore riscvCoreProps i_props (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .iMemRead(iMemRead),
    .dataReq (dataReq)
);

// File: test/tbRiscvCore.sv
// Random-program testbench for riscvCore with an in-order ISA model
// Programs use x0 to x7 only, set x1 to x7 first and keep data addresses below 256
// The DUT store stream is compared in order against the model's store stream
module tbRiscvCore import riscvPkg::*; ();

    localparam int NUM_PROGS = 12;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] dReadData = '0;
    logic [XLEN-1:0] pc;
    logic            iMemRead;
    dataMemReq_t     dataReq;

    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [64];
    logic [XLEN-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];
    logic [2:0]      brF3 [4] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE};
    int              progLen = 0;
    int              errorCount = 0;
    int              checkCount = 0;
    int              cycleNow = 0;
    int              progStart = 0;
    int              cycleLimit = 0;
    logic            running = 1'b0;
    string           testName = "";

    riscvCore i_dut (.*);

    always #2 clk = ~clk;

    // Instruction memory answers in the same cycle
    assign instr = imem[pc[9:2]];

    // Data memory writes on the edge and returns read data one cycle later
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
            dReadData <= '0;
        end else begin
            if (dataReq.write) begin
                dmem[dataReq.addr[7:2]] <= dataReq.writeData;
            end
            if (dataReq.read) begin
                dReadData <= dmem[dataReq.addr[7:2]];
            end
        end
    end

    // Per-program cycle budget
    always @(posedge clk) begin
        cycleNow <= cycleNow + 1;
        if (running && (cycleNow - progStart) > cycleLimit) begin
            $display("Timeout: %s did not finish its stores within %0d cycles",
                     testName, cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Instruction encoders and program generator
    //////////////////////////////////////////////////
    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Encodes sw with funct3 010
    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [4:0] randReg();
        return 5'($urandom % 8);
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic emitAlu(input logic [4:0] src);
        logic [2:0] f3;
        logic       alt;
        f3 = 3'($urandom);
        // No sltu in this core
        if (f3 == 3'b011) begin
            f3 = F3_ADD;
        end
        if ($urandom % 2 == 1) begin
            alt = (f3 == F3_ADD || f3 == F3_SR) && ($urandom % 2 == 1);
            emit(encR(alt ? F7_ALT : 7'd0, randReg(), src, f3, randReg()));
        end else if (f3 == F3_SLL || f3 == F3_SR) begin
            alt = (f3 == F3_SR) && ($urandom % 2 == 1);
            emit(encI({alt ? F7_ALT : 7'd0, 5'($urandom)}, src, f3, randReg(), OP_ITYPE));
        end else begin
            emit(encI(12'($urandom), src, f3, randReg(), OP_ITYPE));
        end
    endtask

    // Mode 0 ALU chains, mode 1 load heavy, mode 2 adds forward branches
    task automatic genProgram(input int mode);
        int         kind;
        logic [4:0] src;
        logic [4:0] rd;
        progLen = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = encI(12'(i), 5'd0, F3_ADD, 5'd0, OP_ITYPE);
        end
        for (int r = 1; r < 8; r++) begin
            emit(encI(12'($urandom), 5'd0, F3_ADD, 5'(r), OP_ITYPE));
        end
        repeat (40 + $urandom % 40) begin
            kind = int'($urandom % 10);
            // Half the time read the previous destination
            src = ($urandom % 2 == 1) ? {2'b00, imem[progLen-1][9:7]} : randReg();
            if (mode == 0 || kind >= 7) begin
                emitAlu(src);
            end else if (mode == 2 && kind < 3) begin
                emit(encB(13'((1 + $urandom % 4) * 4), randReg(), src, brF3[2'($urandom)]));
            end else if (kind < 5) begin
                rd = randReg();
                emit(encI(12'(($urandom % 64) * 4), 5'd0, 3'b010, rd, OP_LOAD));
                emitAlu(rd);
            end else begin
                emit(encS(12'(($urandom % 64) * 4), src, 5'd0));
            end
        end
        for (int r = 0; r < 8; r++) begin
            emit(encS(12'(224 + r * 4), 5'(r), 5'd0));
        end
        emit(encB(13'd0, 5'd0, 5'd0, F3_BEQ));
    endtask

    //////////////////////////////////////////////////
    // ISA model
    //////////////////////////////////////////////////
    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // Runs until the closing self-loop and records every store
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] immB;
        int          idx;
        int          steps;
        bit          done;
        regs = '{default: '0};
        mem = '{default: '0};
        idx = 0;
        steps = 0;
        done = 1'b0;
        expAddr.delete();
        expData.delete();
        while (!done && steps < 4096) begin
            w = imem[idx];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            idx++;
            steps++;
            case (w[6:0])
                OP_RTYPE: regs[w[11:7]] = aluModel(w[14:12], w[30], a, b);
                OP_ITYPE: regs[w[11:7]] = aluModel(w[14:12], w[30] && w[14:12] == F3_SR, a,
                                                   {{20{w[31]}}, w[31:20]});
                OP_LOAD: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    regs[w[11:7]] = mem[addr[7:2]];
                end
                OP_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[7:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                OP_BRANCH: begin
                    if (branchTaken(w[14:12], a, b)) begin
                        done = (immB == 32'd0);
                        idx = idx - 1 + int'(immB >> 2);
                    end
                end
                default: begin
                end
            endcase
            regs[0] = '0;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(35));
        for (int p = 0; p < NUM_PROGS; p++) begin
            testName = $sformatf("prog%0d_mode%0d", p, p % 3);
            // Reset is already high for the first program
            if (p > 0) begin
                @(posedge clk);
                rst <= 1'b1;
            end
            genProgram(p % 3);
            runModel();
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            checkEq({testName, " reset pc"}, INITIAL_PC, pc);
            checkEq({testName, " reset strobes"}, 32'd0, {30'd0, dataReq.read, dataReq.write});
            progStart = cycleNow;
            cycleLimit = progLen * 4 + 50;
            running = 1'b1;
            while (expAddr.size() > 0) begin
                @(negedge clk);
                if (dataReq.write) begin
                    checkEq({testName, " store addr"}, expAddr.pop_front(), dataReq.addr);
                    checkEq({testName, " store data"}, expData.pop_front(), dataReq.writeData);
                end
            end
            // Core now spins on the closing branch
            repeat (12) begin
                @(negedge clk);
                if (dataReq.write) begin
                    errorCount++;
                    $display("%s: unexpected store to 0x%08h after the last expected store",
                             testName, dataReq.addr);
                end
            end
            running = 1'b0;
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: riscvCore.f
hdl/riscvPkg.sv
hdl/fetchUnit.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/hazardControl.sv
hdl/executeUnit.sv
hdl/memWriteback.sv
hdl/riscvCore.sv
test/riscvCore_props.sv
test/tbRiscvCore.sv

// File: run.sh
#!/bin/sh
# Build and run the riscvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbRiscvCore \
    -f riscvCore.f -o tbRiscvCore

out=$(./obj_dir/tbRiscvCore 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "=== PASS ==="
